/* sim.f */
+incdir+.
ipg_pkg.sv
sync_fifo.sv
req_gen.sv
buf_mon.sv
ipg_tx.sv
tb_ipg_tx.sv

/* run.sh */
#!/bin/sh
# Compile with Verilator and run the testbench
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f sim.f --top-module tb_ipg_tx -o tb_ipg_tx

./obj_dir/tb_ipg_tx | tee sim.log

if grep -q "^TEST PASS$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* tb_ipg_tx.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ipg_consts.svh"

module tb_ipg_tx;

    logic                clk;
    logic                reset;
    logic                net_write;
    ipg_pkg::hdr_t       encoded_tx_hdr;
    ipg_pkg::word_t      encoded_tx_data;
    logic                mem_write;
    ipg_pkg::word_t      ipg_reply_chunk;
    logic                req_strobe;
    logic [31:0]         req_addr;
    logic                req_ready;
    ipg_pkg::hdr_t       proced_encoded_tx_hdr;
    ipg_pkg::word_t      proced_encoded_tx_data;
    logic                tx_pause;

    ipg_pkg::net_block_t exp_net[$];  // Non-idle frame blocks in write order
    ipg_pkg::word_t      exp_mem[$];
    ipg_pkg::req_word_t  exp_req[$];  // Two entries per request
    logic [31:0]         rng;
    logic [7:0]          seq_model;
    logic                req_pending;  // First request word seen, second due next
    logic                monitor_on;
    logic                saw_pause;
    int                  frame_left;
    int                  gap_left;
    int                  cycles;

    ipg_tx dut0 (
        .clk(clk), .reset(reset), .net_write(net_write), .encoded_tx_hdr(encoded_tx_hdr),
        .encoded_tx_data(encoded_tx_data), .mem_write(mem_write),
        .ipg_reply_chunk(ipg_reply_chunk), .req_strobe(req_strobe), .req_addr(req_addr),
        .req_ready(req_ready), .proced_encoded_tx_hdr(proced_encoded_tx_hdr),
        .proced_encoded_tx_data(proced_encoded_tx_data), .tx_pause(tx_pause)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function logic [31:0] next_rand();
        rng = rng ^ (rng << 13);  // xorshift32
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function logic is_idle(input ipg_pkg::net_block_t blk);
        return (blk.hdr == `IPG_SYNC_CTRL) && (blk.data[7:0] == `IPG_BT_IDLE);
    endfunction

    // Next block of the MAC stream: start, data, terminate, then a run of idles
    function ipg_pkg::net_block_t next_net_block(input bit sat);
        ipg_pkg::net_block_t blk;
        if (gap_left > 0) begin
            gap_left = gap_left - 1;
            blk = '{hdr: `IPG_SYNC_CTRL, data: {56'h0, `IPG_BT_IDLE}};
        end else if (frame_left == 0) begin
            frame_left = sat ? 2 + int'(next_rand() % 3) : 2 + int'(next_rand() % 8);
            blk = '{hdr: `IPG_SYNC_CTRL, data: {next_rand(), 24'(next_rand()), 8'h78}};
        end else if (frame_left == 1) begin
            frame_left = 0;
            gap_left   = sat ? 1 : 1 + int'(next_rand() % 6);
            blk = '{hdr: `IPG_SYNC_CTRL, data: {next_rand(), 24'(next_rand()), 8'h87}};
        end else begin
            frame_left = frame_left - 1;
            blk = '{hdr: `IPG_SYNC_DATA, data: {next_rand(), next_rand()}};
        end
        return blk;
    endfunction

    task abort(input string what);
        $display("%s", what);
        $display("TEST FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task check_net(input string name, input ipg_pkg::net_block_t got,
                   input ipg_pkg::net_block_t exp);
        if (got !== exp) begin
            abort($sformatf("ERR %0t %s got=%h exp=%h", $time, name, got, exp));
        end
    endtask

    task check_word(input string name, input ipg_pkg::word_t got, input ipg_pkg::word_t exp);
        if (got !== exp) begin
            abort($sformatf("ERR %0t %s got=%h exp=%h", $time, name, got, exp));
        end
    endtask

    task check_req(input string name, input ipg_pkg::req_word_t got,
                   input ipg_pkg::req_word_t exp);
        if (got !== exp) begin
            abort($sformatf("ERR %0t %s got=%h exp=%h", $time, name, got, exp));
        end
    endtask

    task check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort($sformatf("ERR %0t %s got=%b exp=%b", $time, name, got, exp));
        end
    endtask

    // Sorts one output block by header and type byte
    task classify_output();
        ipg_pkg::net_block_t got_blk;
        ipg_pkg::req_word_t  got_req;
        logic                ctrl;
        got_blk = '{hdr: proced_encoded_tx_hdr, data: proced_encoded_tx_data};
        ctrl    = (proced_encoded_tx_hdr == `IPG_SYNC_CTRL);
        if (req_pending && !(ctrl && proced_encoded_tx_data[7:0] == `IPG_BT_REQ)) begin
            abort("Second request word did not follow the first one at once");
        end else if (is_idle(got_blk)) begin
            // Idle blocks carry nothing to compare
        end else if (ctrl && proced_encoded_tx_data[7:0] == `IPG_BT_REPLY) begin
            if (exp_mem.size() == 0) begin
                abort("A reply word came out while no reply was outstanding");
            end else begin
                check_word("proced_encoded_tx_data", proced_encoded_tx_data,
                           exp_mem.pop_front());
            end
        end else if (ctrl && proced_encoded_tx_data[7:0] == `IPG_BT_REQ) begin
            got_req = '{last: req_pending, data: proced_encoded_tx_data};
            if (exp_req.size() == 0) begin
                abort("A request word came out while no request was outstanding");
            end else begin
                check_req("request_word", got_req, exp_req.pop_front());
                req_pending = !req_pending;
            end
        end else if (exp_net.size() == 0) begin
            abort("A network block came out that was never written");
        end else begin
            check_net("proced_encoded_tx", got_blk, exp_net.pop_front());
        end
    endtask

    always @(negedge clk) begin
        if (monitor_on) begin
            classify_output();
        end
    end

    task drive_cycle(input bit sat);
        ipg_pkg::net_block_t blk;
        ipg_pkg::req_word_t  w;
        @(posedge clk);
        #1;
        net_write  = 1'b0;
        mem_write  = 1'b0;
        req_strobe = 1'b0;
        if (tx_pause) saw_pause = 1'b1;
        if (!tx_pause && (sat || (next_rand() % 4 != 0))) begin  // MAC obeys pause
            blk             = next_net_block(sat);
            net_write       = 1'b1;
            encoded_tx_hdr  = blk.hdr;
            encoded_tx_data = blk.data;
            if (!is_idle(blk)) exp_net.push_back(blk);
        end
        if (!sat && exp_mem.size() < 12 && (next_rand() % 8 == 0)) begin
            mem_write       = 1'b1;
            ipg_reply_chunk = {next_rand(), 24'(next_rand()), `IPG_BT_REPLY};
            exp_mem.push_back(ipg_reply_chunk);
        end
        if (req_ready && (sat || (next_rand() % 8 == 0))) begin
            req_strobe = 1'b1;
            req_addr   = next_rand();
            w = '{last: 1'b0, data: {48'h0, seq_model, `IPG_BT_REQ}};
            exp_req.push_back(w);
            w = '{last: 1'b1, data: {req_addr, 16'h0, seq_model, `IPG_BT_REQ}};
            exp_req.push_back(w);
            seq_model = seq_model + 8'd1;
        end
    endtask

    function logic all_drained();
        return exp_net.size() == 0 && exp_mem.size() == 0 && exp_req.size() == 0
               && !req_pending && !tx_pause;
    endfunction

    initial begin
        reset           = 1'b1;
        net_write       = 1'b0;
        encoded_tx_hdr  = `IPG_SYNC_CTRL;
        encoded_tx_data = '0;
        mem_write       = 1'b0;
        ipg_reply_chunk = '0;
        req_strobe      = 1'b0;
        req_addr        = '0;
        rng             = 32'd46;
        seq_model       = 8'd0;
        req_pending     = 1'b0;
        monitor_on      = 1'b0;
        saw_pause       = 1'b0;
        frame_left      = 0;
        gap_left        = 0;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        repeat (3) begin  // Quiet line after reset
            @(negedge clk);
            check_net("proced_encoded_tx", {proced_encoded_tx_hdr, proced_encoded_tx_data},
                      '{hdr: `IPG_SYNC_CTRL, data: {56'h0, `IPG_BT_IDLE}});
            check_flag("tx_pause", tx_pause, 1'b0);
            check_flag("req_ready", req_ready, 1'b1);
        end
        monitor_on = 1'b1;
        repeat (1500) drive_cycle(1'b0);  // Mixed traffic
        saw_pause = 1'b0;
        cycles    = 0;
        while (!saw_pause && cycles < 2000) begin  // Back-to-back frames, short gaps
            drive_cycle(1'b1);
            cycles = cycles + 1;
        end
        if (!saw_pause) begin
            abort("tx_pause never rose while the MAC wrote back to back");
        end else begin
            repeat (300) drive_cycle(1'b1);
        end
        @(posedge clk);
        #1;
        net_write  = 1'b0;
        mem_write  = 1'b0;
        req_strobe = 1'b0;
        cycles     = 0;
        while (!all_drained() && cycles < 3000) begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        repeat (20) @(posedge clk);  // Catch any stray block
        if (all_drained()) begin
            $display("TEST PASS");
            $finish;
        end else begin
            abort("Expected queues did not drain before the timeout");
        end
    end

endmodule

`default_nettype wire

/* ipg_tx.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ipg_consts.svh"

module ipg_tx (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    net_write,
    input  wire ipg_pkg::hdr_t     encoded_tx_hdr,
    input  wire ipg_pkg::word_t    encoded_tx_data,
    input  wire                    mem_write,
    input  wire ipg_pkg::word_t    ipg_reply_chunk,
    input  wire                    req_strobe,
    input  wire [31:0]             req_addr,
    output logic                   req_ready,
    output ipg_pkg::hdr_t          proced_encoded_tx_hdr,
    output ipg_pkg::word_t         proced_encoded_tx_data,
    output logic                   tx_pause
);

    localparam ipg_pkg::word_t IDLE_WORD = {56'h0, `IPG_BT_IDLE};

    ipg_pkg::net_block_t            net_in;
    ipg_pkg::net_block_t            net_head;
    ipg_pkg::word_t                 mem_head;
    ipg_pkg::req_word_t             req_chunk;
    ipg_pkg::req_word_t             req_head;
    ipg_pkg::tx_sel_t               sel;
    logic                           net_empty;
    logic                           mem_empty;
    logic                           req_empty;
    logic                           net_read;
    logic                           mem_read;
    logic                           req_read;
    logic                           reqq_write;
    logic [`IPG_QUEUE_SPACE_W-1:0]  net_space;
    logic [`IPG_QUEUE_SPACE_W-1:0]  req_space;

    assign net_in.hdr  = encoded_tx_hdr;
    assign net_in.data = encoded_tx_data;

    // Frame blocks from the MAC
    sync_fifo #(.payload_t(ipg_pkg::net_block_t)) netq (
        .clk(clk), .reset(reset), .wr(net_write), .w_data(net_in), .rd(net_read),
        .r_data(net_head), .empty(net_empty), .full(), .space(net_space)
    );

    // Replies from the upstream processor
    sync_fifo #(.payload_t(ipg_pkg::word_t)) memq (
        .clk(clk), .reset(reset), .wr(mem_write), .w_data(ipg_reply_chunk), .rd(mem_read),
        .r_data(mem_head), .empty(mem_empty), .full(), .space()
    );

    // Locally built requests
    sync_fifo #(.payload_t(ipg_pkg::req_word_t)) reqq (
        .clk(clk), .reset(reset), .wr(reqq_write), .w_data(req_chunk), .rd(req_read),
        .r_data(req_head), .empty(req_empty), .full(), .space(req_space)
    );

    req_gen generator (
        .clk(clk), .reset(reset), .req_strobe(req_strobe), .req_addr(req_addr),
        .reqq_space(req_space), .req_ready(req_ready), .reqq_write(reqq_write),
        .req_chunk(req_chunk)
    );

    buf_mon monitor (
        .clk(clk), .reset(reset), .net_empty(net_empty), .net_head(net_head),
        .net_space(net_space), .mem_empty(mem_empty), .req_empty(req_empty),
        .req_head_last(req_head.last), .net_read(net_read), .mem_read(mem_read),
        .req_read(req_read), .sel(sel), .tx_pause(tx_pause)
    );

    // Heads are sampled before the reads of this cycle take effect
    always_ff @(posedge clk) begin
        if (reset) begin
            proced_encoded_tx_hdr  <= `IPG_SYNC_CTRL;
            proced_encoded_tx_data <= IDLE_WORD;
        end else begin
            case (sel)
                ipg_pkg::SEL_MEM: begin
                    proced_encoded_tx_hdr  <= `IPG_SYNC_CTRL;
                    proced_encoded_tx_data <= mem_head;
                end
                ipg_pkg::SEL_REQ: begin
                    proced_encoded_tx_hdr  <= `IPG_SYNC_CTRL;
                    proced_encoded_tx_data <= req_head.data;
                end
                ipg_pkg::SEL_NET: begin
                    proced_encoded_tx_hdr  <= net_head.hdr;  // Keeps its own header
                    proced_encoded_tx_data <= net_head.data;
                end
                default: begin
                    proced_encoded_tx_hdr  <= `IPG_SYNC_CTRL;
                    proced_encoded_tx_data <= IDLE_WORD;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* buf_mon.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ipg_consts.svh"

module buf_mon (
    input  wire                           clk,
    input  wire                           reset,
    input  wire                           net_empty,
    input  wire ipg_pkg::net_block_t      net_head,
    input  wire [`IPG_QUEUE_SPACE_W-1:0]  net_space,
    input  wire                           mem_empty,
    input  wire                           req_empty,
    input  wire                           req_head_last,
    output logic                          net_read,
    output logic                          mem_read,
    output logic                          req_read,
    output ipg_pkg::tx_sel_t              sel,
    output logic                          tx_pause
);

    localparam int SPACE_W = `IPG_QUEUE_SPACE_W;

    logic in_req;    // Between the two words of a request
    logic net_idle;  // Head is an idle block that may be replaced

    assign net_idle = !net_empty
                      && (net_head.hdr == `IPG_SYNC_CTRL)
                      && (net_head.data[7:0] == `IPG_BT_IDLE);

    always_comb begin
        net_read = 1'b0;
        mem_read = 1'b0;
        req_read = 1'b0;
        sel      = ipg_pkg::SEL_NONE;

        if (in_req) begin
            // Second word must follow at once; frame data waits in netq
            if (!req_empty) begin
                sel      = ipg_pkg::SEL_REQ;
                req_read = 1'b1;
                net_read = net_idle;  // Absorb an idle only
            end
        end else if (net_idle) begin
            if (!mem_empty) begin
                sel      = ipg_pkg::SEL_MEM;  // Replies take priority
                mem_read = 1'b1;
                net_read = 1'b1;
            end else if (!req_empty) begin
                sel      = ipg_pkg::SEL_REQ;
                req_read = 1'b1;
                net_read = 1'b1;
            end else begin
                sel      = ipg_pkg::SEL_NET;  // Idle passes through
                net_read = 1'b1;
            end
        end else if (!net_empty) begin
            sel      = ipg_pkg::SEL_NET;  // Frame block
            net_read = 1'b1;
        end else if (!mem_empty) begin
            sel      = ipg_pkg::SEL_MEM;  // Line otherwise idle
            mem_read = 1'b1;
        end else if (!req_empty) begin
            sel      = ipg_pkg::SEL_REQ;
            req_read = 1'b1;
        end
    end

    // A request word read with last clear opens a message, last set closes it
    always_ff @(posedge clk) begin
        if (reset) begin
            in_req <= 1'b0;
        end else if (req_read) begin
            in_req <= !req_head_last;
        end
    end

    assign tx_pause = (net_space < SPACE_W'(`IPG_PAUSE_SPACE));

endmodule

`default_nettype wire

/* req_gen.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ipg_consts.svh"

module req_gen (
    input  wire                           clk,
    input  wire                           reset,
    input  wire                           req_strobe,
    input  wire [31:0]                    req_addr,
    input  wire [`IPG_QUEUE_SPACE_W-1:0]  reqq_space,
    output logic                          req_ready,
    output logic                          reqq_write,
    output ipg_pkg::req_word_t            req_chunk
);

    localparam int SPACE_W = `IPG_QUEUE_SPACE_W;

    typedef enum logic [1:0] {
        EMIT_IDLE,
        EMIT_W0,   // Header word due
        EMIT_W1    // Address word due
    } emit_t;

    emit_t       state;
    logic [7:0]  seq;
    logic [31:0] addr_q;
    logic [15:0] tag;

    // Both words need room, so a message never splits across a full queue
    assign req_ready = (state == EMIT_IDLE) && (reqq_space >= SPACE_W'(2));

    always_ff @(posedge clk) begin
        if (req_strobe && req_ready) begin
            addr_q <= req_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= EMIT_IDLE;
            seq   <= 8'd0;
        end else begin
            case (state)
                EMIT_IDLE: if (req_strobe && req_ready) state <= EMIT_W0;
                EMIT_W0:   state <= EMIT_W1;
                EMIT_W1: begin
                    state <= EMIT_IDLE;
                    seq   <= seq + 8'd1;  // Next message number
                end
                default:   state <= EMIT_IDLE;
            endcase
        end
    end

    assign tag            = {seq, `IPG_BT_REQ};
    assign reqq_write     = (state == EMIT_W0) || (state == EMIT_W1);
    assign req_chunk.last = (state == EMIT_W1);
    assign req_chunk.data = (state == EMIT_W1) ? {addr_q, 16'h0000, tag}
                                               : {32'h0000_0000, 16'h0000, tag};

endmodule

`default_nettype wire

/* sync_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ipg_consts.svh"

module sync_fifo #(
    parameter type payload_t = logic [63:0]
) (
    input  wire                            clk,
    input  wire                            reset,
    input  wire                            wr,
    input  wire payload_t                  w_data,
    input  wire                            rd,
    output payload_t                       r_data,
    output logic                           empty,
    output logic                           full,
    output logic [`IPG_QUEUE_SPACE_W-1:0]  space
);

    localparam int DEPTH   = `IPG_QUEUE_DEPTH;
    localparam int SPACE_W = `IPG_QUEUE_SPACE_W;
    localparam int PTR_W   = $clog2(DEPTH);

    payload_t           mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [SPACE_W-1:0] count;
    logic               do_wr;
    logic               do_rd;

    assign do_wr = wr && !full;   // Drop writes when full
    assign do_rd = rd && !empty;  // Drop reads when empty

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= w_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Both or neither
            endcase
        end
    end

    assign r_data = mem[rd_ptr];  // Head always presented
    assign empty  = (count == '0);
    assign full   = (count == SPACE_W'(DEPTH));
    assign space  = SPACE_W'(DEPTH) - count;

endmodule

`default_nettype wire

/* ipg_pkg.sv */
`default_nettype none

package ipg_pkg;

    typedef logic [63:0] word_t;  // Block payload
    typedef logic [1:0]  hdr_t;   // Sync header

    // Network queue entry, one full 66-bit block
    typedef struct packed {
        hdr_t  hdr;
        word_t data;
    } net_block_t;

    // Request queue entry
    typedef struct packed {
        logic  last;  // Final word of a request message
        word_t data;
    } req_word_t;

    // Output source chosen by the monitor
    typedef enum logic [1:0] {
        SEL_NONE = 2'b00,  // Default idle block
        SEL_REQ  = 2'b01,
        SEL_MEM  = 2'b10,
        SEL_NET  = 2'b11
    } tx_sel_t;

endpackage

`default_nettype wire

/* ipg_consts.svh */
`ifndef IPG_CONSTS_SVH
`define IPG_CONSTS_SVH

// 10GBASE-R sync headers
`define IPG_SYNC_DATA 2'b10
`define IPG_SYNC_CTRL 2'b01

// Block type byte, found in bits 7:0 of a control block
`define IPG_BT_IDLE  8'h1e  // All-idle control block
`define IPG_BT_REQ   8'h4b  // Request word in the gap
`define IPG_BT_REPLY 8'h2d  // Reply word in the gap

// Queue sizing, shared by all three queues
`define IPG_QUEUE_DEPTH   16
`define IPG_QUEUE_SPACE_W 5  // Holds 0 to IPG_QUEUE_DEPTH

// MAC is paused while netq free space is below this
`define IPG_PAUSE_SPACE 4

`endif
